/* mem_pkg.sv */
package mem_pkg;

   localparam int pa_width = 32;
   localparam int line_bits = 128;
   localparam int word_bits = 64;
   localparam int lg_line_bytes = 4;

   typedef logic [pa_width-1:0] addr_t;
   typedef logic [line_bits-1:0] line_t;
   typedef logic [word_bits-1:0] word_t;
   typedef logic [63:0] counter_t;

   typedef enum logic [3:0] {
      mem_ld_line = 4'd4,
      mem_st_word = 4'd7,
      mem_flush = 4'd3
   } mem_opcode_t;

   typedef struct packed {
      addr_t       addr;
      mem_opcode_t opcode;
      line_t       data;  // Store word in the low half.
   } mem_req_t;

   typedef struct packed {
      addr_t addr;
      logic  is_store;
      word_t data;
   } data_req_t;

   // Address bit just above the word offset picks the half.
   function automatic word_t line_word(line_t line, logic sel);
      return sel ? line[line_bits-1:word_bits] : line[word_bits-1:0];
   endfunction

   function automatic addr_t line_addr(addr_t addr);
      return {addr[pa_width-1:lg_line_bytes], {lg_line_bytes{1'b0}}};
   endfunction

endpackage

/* l1i_cache.sv */
`timescale 1ns/1ps

module l1i_cache #(
   parameter int lg_lines = 3
)
(
   input  logic              clk,
   input  logic              reset,
   input  logic              fetch_valid,
   input  mem_pkg::addr_t    fetch_addr,
   output logic              fetch_ready,
   output logic              fetch_rsp_valid,
   output mem_pkg::word_t    fetch_rsp_word,
   input  logic              flush_req,
   output logic              flush_complete,
   output logic              req_valid,
   output mem_pkg::mem_req_t req,
   input  logic              rsp_valid,
   input  mem_pkg::line_t    rsp_data,
   output mem_pkg::counter_t cache_accesses,
   output mem_pkg::counter_t cache_hits
);
   import mem_pkg::*;

   localparam int n_lines = 1 << lg_lines;
   localparam int tag_bits = pa_width - lg_line_bytes - lg_lines;

   typedef enum logic [1:0] {st_idle, st_miss, st_flush} state_t;

   state_t state;
   logic [n_lines-1:0] line_valid;
   logic [tag_bits-1:0] tag_mem [n_lines];
   line_t line_mem [n_lines];
   logic flush_pending;
   logic [lg_lines-1:0] flush_idx;
   addr_t miss_addr;

   logic [lg_lines-1:0] idx;
   logic [lg_lines-1:0] miss_idx;
   logic [tag_bits-1:0] tag;
   logic accept;
   logic hit;

   assign idx = fetch_addr[lg_line_bytes +: lg_lines];
   assign tag = fetch_addr[pa_width-1 -: tag_bits];
   assign miss_idx = miss_addr[lg_line_bytes +: lg_lines];
   assign fetch_ready = (state == st_idle) && !flush_pending;
   assign accept = fetch_valid && fetch_ready;
   assign hit = line_valid[idx] && (tag_mem[idx] == tag);
   assign flush_complete = (state == st_flush) && (flush_idx == '1);  // Last line cleared.

   assign req = '{addr: line_addr(miss_addr), opcode: mem_ld_line, data: '0};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
         line_valid <= '0;
         flush_pending <= 1'b0;
         flush_idx <= '0;
         req_valid <= 1'b0;
         fetch_rsp_valid <= 1'b0;
         cache_accesses <= '0;
         cache_hits <= '0;
      end
      else
      begin
         fetch_rsp_valid <= 1'b0;
         case (state)
            st_idle:
            begin
               if (flush_pending)
               begin
                  state <= st_flush;
                  flush_pending <= 1'b0;
                  flush_idx <= '0;
               end
               else if (accept)
               begin
                  cache_accesses <= cache_accesses + 1'b1;
                  if (hit)
                  begin
                     cache_hits <= cache_hits + 1'b1;
                     fetch_rsp_valid <= 1'b1;
                  end
                  else
                  begin
                     state <= st_miss;
                     req_valid <= 1'b1;
                  end
               end
            end
            st_miss:
            begin
               if (rsp_valid)
               begin
                  state <= st_idle;
                  req_valid <= 1'b0;
                  line_valid[miss_idx] <= 1'b1;
                  fetch_rsp_valid <= 1'b1;
               end
            end
            st_flush:
            begin
               line_valid[flush_idx] <= 1'b0;
               flush_idx <= flush_idx + 1'b1;
               if (flush_complete)
                  state <= st_idle;
            end
            default:
               state <= st_idle;
         endcase
         if (flush_req)
            flush_pending <= 1'b1;  // Kept until the cache goes idle.
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         miss_addr <= fetch_addr;
         fetch_rsp_word <= line_word(line_mem[idx], fetch_addr[lg_line_bytes-1]);
      end
      if (state == st_miss && rsp_valid)
      begin
         line_mem[miss_idx] <= rsp_data;
         tag_mem[miss_idx] <= miss_addr[pa_width-1 -: tag_bits];
         fetch_rsp_word <= line_word(rsp_data, miss_addr[lg_line_bytes-1]);
      end
   end

endmodule

/* l1d_cache.sv */
`timescale 1ns/1ps

module l1d_cache #(
   parameter int lg_lines = 3
)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               data_valid,
   input  mem_pkg::data_req_t data_req,
   output logic               data_ready,
   output logic               data_rsp_valid,
   output mem_pkg::word_t     data_rsp_word,
   input  logic               flush_req,
   output logic               flush_complete,
   output logic               req_valid,
   output mem_pkg::mem_req_t  req,
   input  logic               rsp_valid,
   input  mem_pkg::line_t     rsp_data,
   output mem_pkg::counter_t  cache_accesses,
   output mem_pkg::counter_t  cache_hits
);
   import mem_pkg::*;

   localparam int n_lines = 1 << lg_lines;
   localparam int tag_bits = pa_width - lg_line_bytes - lg_lines;

   typedef enum logic [1:0] {st_idle, st_fill, st_store, st_flush} state_t;

   state_t state;
   logic [n_lines-1:0] line_valid;
   logic [tag_bits-1:0] tag_mem [n_lines];
   line_t line_mem [n_lines];
   logic flush_pending;
   logic [lg_lines-1:0] flush_idx;
   data_req_t held;

   logic [lg_lines-1:0] idx;
   logic [lg_lines-1:0] held_idx;
   logic [tag_bits-1:0] tag;
   logic accept;
   logic hit;

   assign idx = data_req.addr[lg_line_bytes +: lg_lines];
   assign tag = data_req.addr[pa_width-1 -: tag_bits];
   assign held_idx = held.addr[lg_line_bytes +: lg_lines];
   assign data_ready = (state == st_idle) && !flush_pending;
   assign accept = data_valid && data_ready;
   assign hit = line_valid[idx] && (tag_mem[idx] == tag);
   assign flush_complete = (state == st_flush) && (flush_idx == '1);

   // Stores go out as a single word, loads as a whole line.
   assign req = '{addr: held.is_store ? held.addr : line_addr(held.addr),
                  opcode: held.is_store ? mem_st_word : mem_ld_line,
                  data: line_t'(held.data)};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
         line_valid <= '0;
         flush_pending <= 1'b0;
         flush_idx <= '0;
         req_valid <= 1'b0;
         data_rsp_valid <= 1'b0;
         cache_accesses <= '0;
         cache_hits <= '0;
      end
      else
      begin
         data_rsp_valid <= 1'b0;
         case (state)
            st_idle:
            begin
               if (flush_pending)
               begin
                  state <= st_flush;
                  flush_pending <= 1'b0;
                  flush_idx <= '0;
               end
               else if (accept)
               begin
                  cache_accesses <= cache_accesses + 1'b1;
                  if (hit)
                     cache_hits <= cache_hits + 1'b1;
                  if (data_req.is_store)
                  begin
                     state <= st_store;  // Write through, hit or miss.
                     req_valid <= 1'b1;
                  end
                  else if (hit)
                     data_rsp_valid <= 1'b1;
                  else
                  begin
                     state <= st_fill;
                     req_valid <= 1'b1;
                  end
               end
            end
            st_fill, st_store:
            begin
               if (rsp_valid)
               begin
                  state <= st_idle;
                  req_valid <= 1'b0;
                  data_rsp_valid <= 1'b1;
                  if (state == st_fill)
                     line_valid[held_idx] <= 1'b1;
               end
            end
            st_flush:
            begin
               line_valid[flush_idx] <= 1'b0;
               flush_idx <= flush_idx + 1'b1;
               if (flush_complete)
                  state <= st_idle;
            end
            default:
               state <= st_idle;
         endcase
         if (flush_req)
            flush_pending <= 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         held <= data_req;
         data_rsp_word <= line_word(line_mem[idx], data_req.addr[lg_line_bytes-1]);
         if (data_req.is_store && hit)
         begin
            if (data_req.addr[lg_line_bytes-1])
               line_mem[idx][line_bits-1:word_bits] <= data_req.data;
            else
               line_mem[idx][word_bits-1:0] <= data_req.data;
         end
      end
      if (state == st_fill && rsp_valid)
      begin
         line_mem[held_idx] <= rsp_data;
         tag_mem[held_idx] <= held.addr[pa_width-1 -: tag_bits];
         data_rsp_word <= line_word(rsp_data, held.addr[lg_line_bytes-1]);
      end
      if (state == st_store && rsp_valid)
         data_rsp_word <= held.data;  // Echo of the stored word.
   end

endmodule

/* mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter
(
   input  logic              clk,
   input  logic              reset,
   input  logic              flush_req_valid,
   input  mem_pkg::mem_req_t flush_req,
   output logic              flush_rsp_valid,
   input  logic              l1d_req_valid,
   input  mem_pkg::mem_req_t l1d_req,
   output logic              l1d_rsp_valid,
   input  logic              l1i_req_valid,
   input  mem_pkg::mem_req_t l1i_req,
   output logic              l1i_rsp_valid,
   output mem_pkg::line_t    rsp_data,
   output logic              mem_req_valid,
   output mem_pkg::mem_req_t mem_req,
   input  logic              mem_rsp_valid,
   input  mem_pkg::line_t    mem_rsp_load_data
);
   import mem_pkg::*;

   typedef enum logic [1:0] {gnt_flush, gnt_l1d, gnt_l1i} grant_t;

   logic busy;
   grant_t grantee;
   grant_t pick;
   mem_req_t pick_req;
   logic any_req;
   logic grant;
   logic done;

   // Fixed priority, flush first.
   always_comb
   begin
      pick = gnt_l1i;
      pick_req = l1i_req;
      if (flush_req_valid)
      begin
         pick = gnt_flush;
         pick_req = flush_req;
      end
      else if (l1d_req_valid)
      begin
         pick = gnt_l1d;
         pick_req = l1d_req;
      end
   end

   assign any_req = flush_req_valid || l1d_req_valid || l1i_req_valid;
   assign grant = !busy && any_req;
   assign done = busy && mem_rsp_valid;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         grantee <= gnt_flush;
         mem_req_valid <= 1'b0;
      end
      else
      begin
         mem_req_valid <= grant;  // One cycle pulse.
         if (grant)
         begin
            busy <= 1'b1;
            grantee <= pick;
         end
         else if (done)
            busy <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (grant)
         mem_req <= pick_req;
   end

   assign flush_rsp_valid = done && (grantee == gnt_flush);
   assign l1d_rsp_valid = done && (grantee == gnt_l1d);
   assign l1i_rsp_valid = done && (grantee == gnt_l1i);
   assign rsp_data = mem_rsp_load_data;

endmodule

/* flush_coordinator.sv */
`timescale 1ns/1ps

module flush_coordinator
(
   input  logic              clk,
   input  logic              reset,
   input  logic              flush_l1i,
   input  logic              flush_l1d,
   input  logic              l1i_flush_complete,
   input  logic              l1d_flush_complete,
   output logic              req_valid,
   output mem_pkg::mem_req_t req,
   input  logic              rsp_valid,
   output logic              in_flush_mode
);
   import mem_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_wait_both,
      st_got_l1d,
      st_got_l1i,
      st_flush_mem
   } state_t;

   state_t state;
   state_t next_state;
   logic next_flush_mode;

   always_comb
   begin
      next_state = state;
      next_flush_mode = in_flush_mode;
      case (state)
         st_idle:
         begin
            if (flush_l1i || flush_l1d)
               next_flush_mode = 1'b1;
            if (flush_l1i && flush_l1d)
               next_state = st_wait_both;
            else if (flush_l1i)
               next_state = st_got_l1d;  // Data cache not asked, counts as done.
            else if (flush_l1d)
               next_state = st_got_l1i;
         end
         st_wait_both:
         begin
            if (l1d_flush_complete && l1i_flush_complete)
               next_state = st_flush_mem;
            else if (l1d_flush_complete)
               next_state = st_got_l1d;
            else if (l1i_flush_complete)
               next_state = st_got_l1i;
         end
         st_got_l1d:
         begin
            if (l1i_flush_complete)
               next_state = st_flush_mem;
         end
         st_got_l1i:
         begin
            if (l1d_flush_complete)
               next_state = st_flush_mem;
         end
         st_flush_mem:
         begin
            if (rsp_valid)
            begin
               next_state = st_idle;
               next_flush_mode = 1'b0;
            end
         end
         default:
            next_state = st_idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= st_idle;
         in_flush_mode <= 1'b0;
      end
      else
      begin
         state <= next_state;
         in_flush_mode <= next_flush_mode;
      end
   end

   assign req_valid = (state == st_flush_mem);  // Held until answered.
   assign req = '{addr: '0, opcode: mem_flush, data: '0};

endmodule

/* mem_subsystem.sv */
`timescale 1ns/1ps

module mem_subsystem #(
   parameter int lg_lines = 3
)
(
   input  logic               clk,
   input  logic               reset,
   input  logic               fetch_valid,
   input  mem_pkg::addr_t     fetch_addr,
   output logic               fetch_ready,
   output logic               fetch_rsp_valid,
   output mem_pkg::word_t     fetch_rsp_word,
   input  logic               data_valid,
   input  mem_pkg::data_req_t data_req,
   output logic               data_ready,
   output logic               data_rsp_valid,
   output mem_pkg::word_t     data_rsp_word,
   input  logic               flush_l1i,
   input  logic               flush_l1d,
   output logic               in_flush_mode,
   output logic               mem_req_valid,
   output mem_pkg::mem_req_t  mem_req,
   input  logic               mem_rsp_valid,
   input  mem_pkg::line_t     mem_rsp_load_data,
   output mem_pkg::counter_t  l1i_cache_accesses,
   output mem_pkg::counter_t  l1i_cache_hits,
   output mem_pkg::counter_t  l1d_cache_accesses,
   output mem_pkg::counter_t  l1d_cache_hits
);
   import mem_pkg::*;

   logic l1i_req_valid;
   mem_req_t l1i_req;
   logic l1i_rsp_valid;
   logic l1d_req_valid;
   mem_req_t l1d_req;
   logic l1d_rsp_valid;
   logic flush_req_valid;
   mem_req_t flush_req;
   logic flush_rsp_valid;
   line_t rsp_data;  // Shared by all three requesters.
   logic l1i_flush_complete;
   logic l1d_flush_complete;

   l1i_cache #(
      .lg_lines(lg_lines)
   ) i_l1i_cache (
      .clk(clk),
      .reset(reset),
      .fetch_valid(fetch_valid),
      .fetch_addr(fetch_addr),
      .fetch_ready(fetch_ready),
      .fetch_rsp_valid(fetch_rsp_valid),
      .fetch_rsp_word(fetch_rsp_word),
      .flush_req(flush_l1i),
      .flush_complete(l1i_flush_complete),
      .req_valid(l1i_req_valid),
      .req(l1i_req),
      .rsp_valid(l1i_rsp_valid),
      .rsp_data(rsp_data),
      .cache_accesses(l1i_cache_accesses),
      .cache_hits(l1i_cache_hits)
   );

   l1d_cache #(
      .lg_lines(lg_lines)
   ) i_l1d_cache (
      .clk(clk),
      .reset(reset),
      .data_valid(data_valid),
      .data_req(data_req),
      .data_ready(data_ready),
      .data_rsp_valid(data_rsp_valid),
      .data_rsp_word(data_rsp_word),
      .flush_req(flush_l1d),
      .flush_complete(l1d_flush_complete),
      .req_valid(l1d_req_valid),
      .req(l1d_req),
      .rsp_valid(l1d_rsp_valid),
      .rsp_data(rsp_data),
      .cache_accesses(l1d_cache_accesses),
      .cache_hits(l1d_cache_hits)
   );

   flush_coordinator i_flush_coordinator (
      .clk(clk),
      .reset(reset),
      .flush_l1i(flush_l1i),
      .flush_l1d(flush_l1d),
      .l1i_flush_complete(l1i_flush_complete),
      .l1d_flush_complete(l1d_flush_complete),
      .req_valid(flush_req_valid),
      .req(flush_req),
      .rsp_valid(flush_rsp_valid),
      .in_flush_mode(in_flush_mode)
   );

   mem_arbiter i_mem_arbiter (
      .clk(clk),
      .reset(reset),
      .flush_req_valid(flush_req_valid),
      .flush_req(flush_req),
      .flush_rsp_valid(flush_rsp_valid),
      .l1d_req_valid(l1d_req_valid),
      .l1d_req(l1d_req),
      .l1d_rsp_valid(l1d_rsp_valid),
      .l1i_req_valid(l1i_req_valid),
      .l1i_req(l1i_req),
      .l1i_rsp_valid(l1i_rsp_valid),
      .rsp_data(rsp_data),
      .mem_req_valid(mem_req_valid),
      .mem_req(mem_req),
      .mem_rsp_valid(mem_rsp_valid),
      .mem_rsp_load_data(mem_rsp_load_data)
   );

endmodule

/* mem_subsystem_checker.sv */
`timescale 1ns/1ps

module mem_subsystem_checker
(
   input logic clk,
   input logic reset,
   input logic mem_req_valid,
   input logic mem_rsp_valid,
   input logic in_flush_mode
);

   logic outstanding;

   always_ff @(posedge clk)
   begin
      if (reset)
         outstanding <= 1'b0;
      else if (mem_req_valid)
         outstanding <= 1'b1;
      else if (mem_rsp_valid)
         outstanding <= 1'b0;  // Memory answered.
   end

   one_outstanding: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |-> !outstanding)
      else $error("mem_req_valid issued before the previous mem_rsp_valid");

   req_single_cycle: assert property (@(posedge clk) disable iff (reset)
      mem_req_valid |=> !mem_req_valid)
      else $error("mem_req_valid held longer than one cycle");

   flush_mode_after_reset: assert property (@(posedge clk)
      reset |=> !in_flush_mode)
      else $error("in_flush_mode high in the cycle after reset");

endmodule

bind mem_subsystem mem_subsystem_checker i_mem_subsystem_checker (
   .clk(clk),
   .reset(reset),
   .mem_req_valid(mem_req_valid),
   .mem_rsp_valid(mem_rsp_valid),
   .in_flush_mode(in_flush_mode)
);

/* tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;
   import mem_pkg::*;

   localparam int clk_period = 40;
   localparam int timeout_cycles = 200;
   localparam logic [31:0] seed = 32'h3bb13dac;

   localparam addr_t addr_a = 32'h0000_1040;
   localparam addr_t addr_d = 32'h0000_2000;
   localparam addr_t addr_e = 32'h0000_3030;
   localparam addr_t addr_f = 32'h0000_4050;
   localparam addr_t addr_g = 32'h0000_5060;
   localparam addr_t addr_x = 32'h0000_6078;  // Same index as addr_y.
   localparam addr_t addr_y = 32'h0000_7070;

   logic clk;
   logic reset;
   logic fetch_valid;
   addr_t fetch_addr;
   logic fetch_ready;
   logic fetch_rsp_valid;
   word_t fetch_rsp_word;
   logic data_valid;
   data_req_t data_req;
   logic data_ready;
   logic data_rsp_valid;
   word_t data_rsp_word;
   logic flush_l1i;
   logic flush_l1d;
   logic in_flush_mode;
   logic mem_req_valid;
   mem_req_t mem_req;
   logic mem_rsp_valid;
   line_t mem_rsp_load_data;
   counter_t l1i_cache_accesses;
   counter_t l1i_cache_hits;
   counter_t l1d_cache_accesses;
   counter_t l1d_cache_hits;

   word_t shadow [addr_t];  // Words written by stores.
   mem_opcode_t op_log [$];
   addr_t addr_log [$];
   logic flush_too_early;
   logic [31:0] rng;
   int delay_left;
   mem_req_t pending;
   int errors;
   int checks;
   int tests;

   mem_subsystem #(
      .lg_lines(3)
   ) i_mem_subsystem (.*);

   initial
      clk = 1'b0;
   always
      #(clk_period / 2) clk = ~clk;

   function automatic logic [31:0] xorshift(logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic word_t pattern_word(addr_t a);
      addr_t wa;
      wa = {a[pa_width-1:3], 3'b000};
      return {wa ^ 32'h6c3a_91e5, {wa[15:0], wa[31:16]} + 32'h0102_0304};
   endfunction

   // What memory holds for the word at a.
   function automatic word_t mem_word(addr_t a);
      addr_t wa;
      wa = {a[pa_width-1:3], 3'b000};
      if (shadow.exists(wa))
         return shadow[wa];
      return pattern_word(wa);
   endfunction

   always @(posedge clk)
   begin
      if (reset)
      begin
         mem_rsp_valid <= 1'b0;
         delay_left = 0;
      end
      else
      begin
         mem_rsp_valid <= 1'b0;
         if (mem_req_valid)
         begin
            pending = mem_req;
            op_log.push_back(mem_req.opcode);
            addr_log.push_back(mem_req.addr);
            if (mem_req.opcode == mem_flush && !(fetch_ready && data_ready))
               flush_too_early = 1'b1;  // A cache was still busy.
            if (mem_req.opcode == mem_st_word)
               shadow[{mem_req.addr[pa_width-1:3], 3'b000}] = mem_req.data[word_bits-1:0];
            rng = xorshift(rng);
            delay_left = 1 + int'(rng % 32'd8);
         end
         else if (delay_left > 0)
         begin
            delay_left = delay_left - 1;
            if (delay_left == 0)
            begin
               mem_rsp_valid <= 1'b1;
               mem_rsp_load_data <= {mem_word({pending.addr[pa_width-1:4], 4'h8}),
                                     mem_word({pending.addr[pa_width-1:4], 4'h0})};
            end
         end
      end
   end

   task automatic note_failure(string msg);
      errors++;
      $display("%s", msg);
   endtask

   task automatic check_word(string what, word_t got, word_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_count(string what, counter_t got, counter_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_opcode(string what, mem_opcode_t got, mem_opcode_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_addr(string what, addr_t got, addr_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (!(fetch_ready && data_ready) && n < timeout_cycles)
      begin
         @(posedge clk);
         n++;
      end
      if (!(fetch_ready && data_ready))
         note_failure("Timeout while waiting for both caches to become ready");
   endtask

   task automatic wait_fetch_rsp(output word_t w);
      int n;
      n = 0;
      w = 'x;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!fetch_rsp_valid && n < timeout_cycles);
      if (fetch_rsp_valid)
         w = fetch_rsp_word;
      else
         note_failure("Timeout while waiting for a fetch response");
   endtask

   task automatic wait_data_rsp(output word_t w);
      int n;
      n = 0;
      w = 'x;
      do
      begin
         @(posedge clk);
         n++;
      end
      while (!data_rsp_valid && n < timeout_cycles);
      if (data_rsp_valid)
         w = data_rsp_word;
      else
         note_failure("Timeout while waiting for a data response");
   endtask

   task automatic wait_flush_done();
      int n;
      n = 0;
      while (in_flush_mode && n < timeout_cycles)
      begin
         @(posedge clk);
         n++;
      end
      if (in_flush_mode)
         note_failure("Timeout while waiting for in_flush_mode to fall");
   endtask

   task automatic fetch_and_check(addr_t a);
      word_t w;
      wait_idle();
      fetch_valid <= 1'b1;
      fetch_addr <= a;
      @(posedge clk);
      fetch_valid <= 1'b0;
      wait_fetch_rsp(w);
      check_word("fetch word", w, mem_word(a));
   endtask

   task automatic data_and_check(addr_t a, logic is_store, word_t wdata);
      word_t w;
      wait_idle();
      data_valid <= 1'b1;
      data_req <= '{addr: a, is_store: is_store, data: wdata};
      @(posedge clk);
      data_valid <= 1'b0;
      wait_data_rsp(w);
      check_word(is_store ? "store echo" : "load word", w, is_store ? wdata : mem_word(a));
   endtask

   task automatic finish_test(string name, int errors_before);
      tests++;
      if (errors == errors_before)
         $display("Test %s: ok", name);
      else
         $display("Test %s: %0d errors", name, errors - errors_before);
   endtask

   task automatic test_fetch_miss_hit();
      int e0;
      counter_t acc0;
      counter_t hit0;
      e0 = errors;
      acc0 = l1i_cache_accesses;
      hit0 = l1i_cache_hits;
      fetch_and_check(addr_a);
      fetch_and_check(addr_a);
      check_count("l1i accesses", l1i_cache_accesses - acc0, 2);
      check_count("l1i hits", l1i_cache_hits - hit0, 1);
      finish_test("fetch miss then hit", e0);
   endtask

   task automatic test_store_hit();
      int e0;
      counter_t acc0;
      counter_t hit0;
      counter_t n_st;
      e0 = errors;
      acc0 = l1d_cache_accesses;
      hit0 = l1d_cache_hits;
      op_log.delete();
      data_and_check(addr_d, 1'b0, '0);
      data_and_check(addr_d + 8, 1'b1, 64'h0123_4567_89ab_cdef);
      data_and_check(addr_d + 8, 1'b0, '0);
      check_word("load after store", mem_word(addr_d + 8), 64'h0123_4567_89ab_cdef);
      n_st = 0;
      foreach (op_log[i])
         if (op_log[i] == mem_st_word)
            n_st++;
      check_count("mem_st_word requests", n_st, 1);
      check_count("l1d accesses", l1d_cache_accesses - acc0, 3);
      check_count("l1d hits", l1d_cache_hits - hit0, 2);
      finish_test("load, store hit, load", e0);
   endtask

   task automatic test_store_miss();
      int e0;
      counter_t hit0;
      e0 = errors;
      hit0 = l1d_cache_hits;
      op_log.delete();
      data_and_check(addr_e, 1'b1, 64'hfeed_0042_a5a5_1234);
      data_and_check(addr_e, 1'b0, '0);
      check_word("load after store miss", mem_word(addr_e), 64'hfeed_0042_a5a5_1234);
      check_count("l1d hits", l1d_cache_hits - hit0, 0);
      check_count("memory requests", op_log.size(), 2);
      check_opcode("first request", op_log[0], mem_st_word);
      check_opcode("second request", op_log[1], mem_ld_line);
      finish_test("store miss does not allocate", e0);
   endtask

   task automatic test_parallel_miss();
      int e0;
      word_t fw;
      word_t dw;
      e0 = errors;
      op_log.delete();
      addr_log.delete();
      wait_idle();
      fetch_valid <= 1'b1;
      fetch_addr <= addr_f;
      data_valid <= 1'b1;
      data_req <= '{addr: addr_g, is_store: 1'b0, data: '0};
      @(posedge clk);
      fetch_valid <= 1'b0;
      data_valid <= 1'b0;
      fork
         wait_fetch_rsp(fw);
         wait_data_rsp(dw);
      join
      check_word("fetch word", fw, mem_word(addr_f));
      check_word("load word", dw, mem_word(addr_g));
      check_count("memory requests", op_log.size(), 2);
      check_opcode("first request", op_log[0], mem_ld_line);
      check_addr("first request address", addr_log[0], {addr_g[pa_width-1:4], 4'h0});
      finish_test("simultaneous misses", e0);
   endtask

   task automatic test_flush();
      int e0;
      counter_t hit0;
      e0 = errors;
      fetch_and_check(addr_a);
      wait_idle();
      op_log.delete();
      flush_too_early = 1'b0;
      flush_l1i <= 1'b1;
      flush_l1d <= 1'b1;
      @(posedge clk);
      flush_l1i <= 1'b0;
      flush_l1d <= 1'b0;
      @(posedge clk);
      if (!in_flush_mode)
         note_failure("in_flush_mode did not rise one cycle after the flush pulses");
      wait_flush_done();
      check_count("memory requests", op_log.size(), 1);
      check_opcode("flush request", op_log[0], mem_flush);
      if (flush_too_early)
         note_failure("Memory flush arrived before both caches finished flushing");
      hit0 = l1i_cache_hits;
      fetch_and_check(addr_a);
      check_count("l1i hits after flush", l1i_cache_hits - hit0, 0);
      finish_test("flush both caches", e0);
   endtask

   task automatic test_eviction();
      int e0;
      counter_t acc0;
      counter_t hit0;
      e0 = errors;
      acc0 = l1i_cache_accesses;
      hit0 = l1i_cache_hits;
      fetch_and_check(addr_x);
      fetch_and_check(addr_y);
      fetch_and_check(addr_x);
      fetch_and_check(addr_y);
      check_count("l1i accesses", l1i_cache_accesses - acc0, 4);
      check_count("l1i hits", l1i_cache_hits - hit0, 0);
      finish_test("conflict eviction", e0);
   endtask

   initial
   begin
      reset = 1'b1;
      fetch_valid = 1'b0;
      fetch_addr = '0;
      data_valid = 1'b0;
      data_req = '0;
      flush_l1i = 1'b0;
      flush_l1d = 1'b0;
      mem_rsp_valid = 1'b0;
      mem_rsp_load_data = '0;
      rng = seed;
      flush_too_early = 1'b0;
      errors = 0;
      checks = 0;
      tests = 0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      test_fetch_miss_hit();
      test_store_hit();
      test_store_miss();
      test_parallel_miss();
      test_flush();
      test_eviction();
      $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

/* sources.f */
mem_pkg.sv
l1i_cache.sv
l1d_cache.sv
mem_arbiter.sv
flush_coordinator.sv
mem_subsystem.sv
mem_subsystem_checker.sv
tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - mem_pkg.sv
  - l1i_cache.sv
  - l1d_cache.sv
  - mem_arbiter.sv
  - flush_coordinator.sv
  - mem_subsystem.sv
  - target: test
    files:
      - mem_subsystem_checker.sv
      - tb_mem_subsystem.sv
